// ==== dv/ppu_assert.sv ====
`default_nettype none

`include "ppu_settings.svh"

module ppu_vram_assert (
    input logic clk,
    input logic reset,
    input logic vblank,
    input logic hsync,
    input logic mem_rd,
    input ppu_pkg::addr_t mem_addr
);

    import ppu_pkg::*;

    // Memory is only touched in blanking
    rd_in_blank: assert property (@(posedge clk) disable iff (reset)
        mem_rd |-> (vblank || hsync))
        else $error("memory read outside vblank and hsync");

    rd_addr_known: assert property (@(posedge clk) disable iff (reset)
        mem_rd |-> !$isunknown(mem_addr))
        else $error("memory read with unknown address");

    // Palette region only during vblank
    pal_region: assert property (@(posedge clk) disable iff (reset)
        (vblank && !hsync && mem_rd)
            |-> ((mem_addr - addr_t'(`PPU_PAL_BASE)) < addr_t'(`PPU_PAL_ENTRIES)))
        else $error("vblank read at %h outside the palette region", mem_addr);

    tile_region: assert property (@(posedge clk) disable iff (reset)
        (hsync && !vblank && mem_rd) |-> (mem_addr >= addr_t'(`PPU_MAP_BASE)))
        else $error("hsync read at %h below the tile map region", mem_addr);

endmodule

bind ppu_top ppu_vram_assert vram_chk0 (
    .clk, .reset, .vblank, .hsync, .mem_rd, .mem_addr
);

`default_nettype wire

// ==== dv/tb_ppu.sv ====
`default_nettype none

`include "ppu_settings.svh"

module tb_ppu;

    import ppu_pkg::*;

    localparam int N_ROWS = 6;
    localparam int RESET_CYCLES = 10;
    localparam int VBLANK_CYCLES = 16;
    localparam int HSYNC_CYCLES = 128;
    localparam int ACTIVE_BUDGET = 1400; // Upper bound on active cycles per row
    localparam int LIMIT = RESET_CYCLES + N_ROWS * (VBLANK_CYCLES + HSYNC_CYCLES + ACTIVE_BUDGET)
                         + 500;

    // Table row with the line to fetch, four hcounts to sample and the vblank options
    typedef struct packed {
        logic [9:0] vcount;
        logic [3:0][10:0] hc;
        logic vblank_first;
        logic new_pal; // Rewrite palette memory before the vblank
    } stim_t;

    logic clk;
    logic reset;
    logic vblank;
    logic hsync;
    logic [10:0] hcount;
    logic [9:0] vcount;
    color_t pixel_color;
    logic mem_rd;
    addr_t mem_addr;
    word_t mem_rdata = '0;

    word_t vram [4096];
    color_t exp_pal [`PPU_PAL_ENTRIES]; // Colors the DUT should hold after the last vblank
    stim_t stim [N_ROWS];
    int color_errors;
    int addr_errors;
    int flag_errors;
    logic upper_seen;
    int unsigned seed;

    ppu_top dut0 (
        .clk, .reset, .vblank, .hsync, .hcount, .vcount,
        .pixel_color,
        .mem_rd, .mem_addr, .mem_rdata
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (mem_rd) mem_rdata <= vram[mem_addr]; // One-cycle registered read
    end

    // Reference pixel from the address rules of the memory layout
    function automatic color_t model_color(logic [9:0] vc, logic [10:0] hc, output logic pal_bit);
        int slot;
        int px;
        word_t map_w;
        word_t gfx_w;
        tile_entry_t ent;
        pal_idx_t idx;
        slot = int'(hc) / 32;
        px = (int'(hc) % 32) / 2;
        map_w = vram[addr_t'(`PPU_MAP_BASE + (int'(vc) / 32) * 10 + slot / 4)];
        ent = tile_entry_t'(map_w[8 * (slot % 4) +: 8]);
        gfx_w = vram[addr_t'(`PPU_GFX_BASE + int'(ent.tile_id) * 16 + (int'(vc) % 32) / 2)];
        idx = {ent.pal, gfx_w[2 * px +: 2]};
        pal_bit = ent.pal;
        return exp_pal[idx];
    endfunction

    task automatic check_color(color_t got, color_t exp, string what);
        if (got !== exp) begin
            color_errors++;
            $display("[FAIL] %0t: %s pixel_color %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(addr_t got, addr_t lo, addr_t hi, string what);
        if ($isunknown(got) || got < lo || got > hi) begin
            addr_errors++;
            $display("[FAIL] %0t: %s mem_addr %h, expected %h to %h", $time, what, got, lo, hi);
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            flag_errors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic run_vblank(logic new_pal);
        @(negedge clk);
        if (new_pal) begin
            for (int i = 0; i < `PPU_PAL_ENTRIES; i++) vram[`PPU_PAL_BASE + i] = $urandom();
        end
        for (int i = 0; i < `PPU_PAL_ENTRIES; i++) begin
            exp_pal[i] = vram[`PPU_PAL_BASE + i][`PPU_COLOR_W-1:0];
        end
        @(posedge clk);
        vblank <= 1'b1;
        repeat (VBLANK_CYCLES) begin
            @(negedge clk);
            if (mem_rd) begin
                check_addr(mem_addr, addr_t'(`PPU_PAL_BASE),
                           addr_t'(`PPU_PAL_BASE + `PPU_PAL_ENTRIES - 1), "vblank read");
            end
        end
        @(posedge clk);
        vblank <= 1'b0;
    endtask

    task automatic run_hsync(logic [9:0] vc);
        @(posedge clk);
        vcount <= vc;
        hsync <= 1'b1;
        repeat (HSYNC_CYCLES) begin
            @(negedge clk);
            if (mem_rd) check_addr(mem_addr, addr_t'(`PPU_MAP_BASE), 12'hfff, "hsync read");
        end
        @(posedge clk);
        hsync <= 1'b0;
    endtask

    task automatic sample_pixel(logic [10:0] hc);
        color_t exp;
        logic pal_bit;
        @(posedge clk);
        hcount <= hc;
        @(posedge clk); // Color is registered on this edge
        @(negedge clk);
        exp = model_color(vcount, hc, pal_bit);
        if (pal_bit) upper_seen = 1'b1;
        check_color(pixel_color, exp, $sformatf("vcount %0d hcount %0d", vcount, hc));
        check_flag(mem_rd, 1'b0, "mem_rd in active video");
    endtask

    initial begin
        seed = $urandom(32);
        reset = 1'b1;
        vblank = 1'b0;
        hsync = 1'b0;
        hcount = '0;
        vcount = '0;
        color_errors = 0;
        addr_errors = 0;
        flag_errors = 0;
        upper_seen = 1'b0;
        // Any 7-bit tile id addresses a row inside the graphics region
        for (int a = 0; a < 4096; a++) vram[a] = $urandom();

        stim[0] = '{vcount: 10'd0, hc: {11'd1279, 11'd300, 11'd37, 11'd0},
                    vblank_first: 1'b1, new_pal: 1'b0};
        stim[1] = '{vcount: 10'd6, hc: {11'd1023, 11'd640, 11'd33, 11'd2},
                    vblank_first: 1'b0, new_pal: 1'b0};
        stim[2] = '{vcount: 10'd31, hc: {11'd1250, 11'd511, 11'd128, 11'd31},
                    vblank_first: 1'b0, new_pal: 1'b0};
        stim[3] = '{vcount: 10'd32, hc: {11'd1200, 11'd700, 11'd95, 11'd1},
                    vblank_first: 1'b1, new_pal: 1'b1}; // Next tile row with a fresh palette
        stim[4] = '{vcount: 10'd517, hc: {11'd1100, 11'd800, 11'd65, 11'd64},
                    vblank_first: 1'b0, new_pal: 1'b0};
        stim[5] = '{vcount: 10'd999, hc: {11'd1278, 11'd960, 11'd480, 11'd17},
                    vblank_first: 1'b1, new_pal: 1'b1};

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_color(pixel_color, '0, "after reset");
        check_flag(mem_rd, 1'b0, "mem_rd after reset");

        for (int r = 0; r < N_ROWS; r++) begin
            if (stim[r].vblank_first) run_vblank(stim[r].new_pal);
            run_hsync(stim[r].vcount);
            for (int j = 0; j < 4; j++) sample_pixel(stim[r].hc[j]);
            // Every tile slot once with the pixel position moving along
            for (int s = 0; s < `PPU_TILES_PER_LINE; s++) sample_pixel(11'(s * 32 + (s % 16) * 2));
        end
        check_flag(upper_seen, 1'b1, "upper palette half sampled");

        $display("Errors: color %0d, address %0d, flag %0d", color_errors, addr_errors,
                 flag_errors);
        if (color_errors + addr_errors + flag_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the test did not complete", LIMIT);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+rtl
rtl/ppu_pkg.sv
rtl/vram_arbiter.sv
rtl/palette_loader.sv
rtl/tile_line_fetcher.sv
rtl/pixel_output.sv
rtl/ppu_top.sv
dv/ppu_assert.sv
dv/tb_ppu.sv

// ==== rtl/palette_loader.sv ====
`default_nettype none

`include "ppu_settings.svh"

module palette_loader (
    input logic clk,
    input logic reset,
    input logic vblank,

    // Read port towards the arbiter
    output logic req,
    output ppu_pkg::addr_t addr,
    input logic gnt,
    input logic rvalid,
    input ppu_pkg::word_t rdata,

    // Lookup from the pixel stage
    input ppu_pkg::pal_idx_t pal_idx,
    output ppu_pkg::color_t pal_color
);

    import ppu_pkg::*;

    logic [3:0] iss;  // Next entry to request, stops at the entry count
    pal_idx_t cap;    // Next entry to capture

    color_t pal_mem [`PPU_PAL_ENTRIES];

    // Request stays up through vblank until every entry has been issued
    assign req = vblank && (iss < `PPU_PAL_ENTRIES);
    assign addr = addr_t'(`PPU_PAL_BASE) + addr_t'(iss);

    always_ff @(posedge clk) begin
        if (reset) begin
            iss <= 4'd0;
            cap <= '0;
        end else if (!vblank) begin
            // Rearm for the next frame
            iss <= 4'd0;
            cap <= '0;
        end else begin
            if (gnt) begin
                iss <= iss + 4'd1;
            end
            if (rvalid) begin
                cap <= cap + 1'b1;
            end
        end
    end

    // Color table, old colors stay until the next load overwrites them
    always_ff @(posedge clk) begin
        if (vblank && rvalid) begin
            pal_mem[cap] <= rdata[`PPU_COLOR_W-1:0];
        end
    end

    assign pal_color = pal_mem[pal_idx]; // Combinational lookup

endmodule

`default_nettype wire

// ==== rtl/pixel_output.sv ====
`default_nettype none

`include "ppu_settings.svh"

module pixel_output (
    input logic clk,
    input logic reset,
    input logic vblank,
    input logic hsync,
    input logic [10:0] hcount,

    // Line buffer fill from the fetcher
    input logic lb_wr,
    input ppu_pkg::tile_idx_t lb_idx,
    input logic lb_pal,
    input ppu_pkg::tile_gfx_t lb_gfx,

    // Palette lookup
    output ppu_pkg::pal_idx_t pal_idx,
    input ppu_pkg::color_t pal_color,

    output ppu_pkg::color_t pixel_color
);

    import ppu_pkg::*;

    tile_gfx_t gfx_buf [`PPU_TILES_PER_LINE];
    logic pal_buf [`PPU_TILES_PER_LINE];

    tile_idx_t slot;
    logic [3:0] px;
    tile_gfx_t cur_gfx;

    always_ff @(posedge clk) begin
        if (lb_wr) begin
            gfx_buf[lb_idx] <= lb_gfx;
            pal_buf[lb_idx] <= lb_pal;
        end
    end

    // Each tile spans 32 hcounts, every pixel shown twice
    assign slot = hcount[10:5];
    assign px = hcount[4:1];
    assign cur_gfx = gfx_buf[slot];

    assign pal_idx = {pal_buf[slot], cur_gfx[px]}; // Palette bit selects upper half

    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_color <= '0;
        end else if (!vblank && !hsync) begin
            pixel_color <= pal_color;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ppu_pkg.sv ====
`default_nettype none

`include "ppu_settings.svh"

package ppu_pkg;

    typedef logic [`PPU_ADDR_W-1:0] addr_t;
    typedef logic [`PPU_DATA_W-1:0] word_t;
    typedef logic [`PPU_COLOR_W-1:0] color_t; // Low bits of a palette word

    // One tile map entry, four of these per map word
    typedef struct packed {
        logic pal;
        logic [6:0] tile_id;
    } tile_entry_t;

    // One graphics row, pixel p at index p
    typedef logic [15:0][1:0] tile_gfx_t;

    typedef logic [5:0] tile_idx_t; // Tile slot on the line
    typedef logic [2:0] pal_idx_t;  // {palette bit, pixel value}

    // Who owns the read that is in flight
    typedef enum logic {
        REQ_PAL,
        REQ_TILE
    } req_id_t;

endpackage

`default_nettype wire

// ==== rtl/ppu_settings.svh ====
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// Bus widths
`define PPU_ADDR_W 12
`define PPU_DATA_W 32
`define PPU_COLOR_W 24

// Palette geometry
`define PPU_PAL_ENTRIES 8

// Background geometry
`define PPU_TILES_PER_LINE 40
`define PPU_TILES_PER_WORD 4 // Map entries packed per memory word
`define PPU_MAP_WORDS_PER_ROW 10
`define PPU_TILE_ROWS 16 // Graphics words per tile

// Video memory regions
`define PPU_PAL_BASE 12'h000
`define PPU_MAP_BASE 12'h100
`define PPU_GFX_BASE 12'h800

`endif

// ==== rtl/ppu_top.sv ====
`default_nettype none

module ppu_top (
    input logic clk,
    input logic reset,
    input logic vblank,
    input logic hsync,
    input logic [10:0] hcount,
    input logic [9:0] vcount,
    output ppu_pkg::color_t pixel_color,

    // Shared video memory read port
    output logic mem_rd,
    output ppu_pkg::addr_t mem_addr,
    input ppu_pkg::word_t mem_rdata
);

    import ppu_pkg::*;

    logic pal_req;
    addr_t pal_addr;
    logic pal_gnt;
    logic pal_rvalid;

    logic tile_req;
    addr_t tile_addr;
    logic tile_gnt;
    logic tile_rvalid;

    word_t rdata;

    logic lb_wr;
    tile_idx_t lb_idx;
    logic lb_pal;
    tile_gfx_t lb_gfx;

    pal_idx_t pal_idx;
    color_t pal_color;

    vram_arbiter arb0 (
        .clk, .reset,
        .pal_req, .pal_addr, .pal_gnt, .pal_rvalid,
        .tile_req, .tile_addr, .tile_gnt, .tile_rvalid,
        .rdata,
        .mem_rd, .mem_addr, .mem_rdata
    );

    palette_loader pal0 (
        .clk, .reset, .vblank,
        .req(pal_req), .addr(pal_addr), .gnt(pal_gnt), .rvalid(pal_rvalid), .rdata,
        .pal_idx, .pal_color
    );

    tile_line_fetcher fetch0 (
        .clk, .reset, .hsync, .vcount,
        .req(tile_req), .addr(tile_addr), .gnt(tile_gnt), .rvalid(tile_rvalid), .rdata,
        .lb_wr, .lb_idx, .lb_pal, .lb_gfx
    );

    pixel_output pix0 (
        .clk, .reset, .vblank, .hsync, .hcount,
        .lb_wr, .lb_idx, .lb_pal, .lb_gfx,
        .pal_idx, .pal_color,
        .pixel_color
    );

endmodule

`default_nettype wire

// ==== rtl/tile_line_fetcher.sv ====
`default_nettype none

`include "ppu_settings.svh"

module tile_line_fetcher (
    input logic clk,
    input logic reset,
    input logic hsync,
    input logic [9:0] vcount,

    // Read port towards the arbiter
    output logic req,
    output ppu_pkg::addr_t addr,
    input logic gnt,
    input logic rvalid,
    input ppu_pkg::word_t rdata,

    // Line buffer write
    output logic lb_wr,
    output ppu_pkg::tile_idx_t lb_idx,
    output logic lb_pal,
    output ppu_pkg::tile_gfx_t lb_gfx
);

    import ppu_pkg::*;

    typedef enum logic [2:0] {
        ST_MAP,       // Request a map word
        ST_MAP_WAIT,
        ST_GFX,       // Request the graphics row of one entry
        ST_GFX_WAIT,
        ST_DONE       // All 40 tiles fetched for this line
    } state_t;

    state_t state;
    logic [3:0] word_idx;  // Map word within the row
    logic [1:0] ent_idx;   // Entry within the map word
    tile_entry_t [3:0] map_q;

    logic [4:0] map_row;
    logic [3:0] gfx_line;
    tile_entry_t entry;
    addr_t map_addr;
    addr_t gfx_addr;

    assign map_row = vcount[9:5];  // 32 lines per tile row
    assign gfx_line = vcount[4:1]; // Lines are doubled
    assign entry = map_q[ent_idx];

    assign map_addr = addr_t'(`PPU_MAP_BASE)
                    + addr_t'(map_row) * addr_t'(`PPU_MAP_WORDS_PER_ROW)
                    + addr_t'(word_idx);
    assign gfx_addr = addr_t'(`PPU_GFX_BASE)
                    + addr_t'(entry.tile_id) * addr_t'(`PPU_TILE_ROWS)
                    + addr_t'(gfx_line);

    assign req = hsync && ((state == ST_MAP) || (state == ST_GFX));
    assign addr = (state == ST_MAP) ? map_addr : gfx_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_MAP;
            word_idx <= 4'd0;
            ent_idx <= 2'd0;
        end else if (!hsync) begin
            state <= ST_MAP;
            word_idx <= 4'd0;
            ent_idx <= 2'd0;
        end else begin
            case (state)
                ST_MAP: begin
                    if (gnt) state <= ST_MAP_WAIT;
                end
                ST_MAP_WAIT: begin
                    if (rvalid) begin
                        ent_idx <= 2'd0;
                        state <= ST_GFX;
                    end
                end
                ST_GFX: begin
                    if (gnt) state <= ST_GFX_WAIT;
                end
                ST_GFX_WAIT: begin
                    if (rvalid) begin
                        if (ent_idx == 2'(`PPU_TILES_PER_WORD - 1)) begin
                            ent_idx <= 2'd0;
                            if (word_idx == 4'(`PPU_MAP_WORDS_PER_ROW - 1)) begin
                                state <= ST_DONE;
                            end else begin
                                word_idx <= word_idx + 4'd1;
                                state <= ST_MAP;
                            end
                        end else begin
                            ent_idx <= ent_idx + 2'd1;
                            state <= ST_GFX;
                        end
                    end
                end
                default: state <= ST_DONE; // Hold until hsync drops
            endcase
        end
    end

    // Map word is payload, kept while its four entries are used
    always_ff @(posedge clk) begin
        if ((state == ST_MAP_WAIT) && rvalid) begin
            map_q <= rdata;
        end
    end

    // Returned graphics row goes straight into slot 4w+k
    assign lb_wr = rvalid && (state == ST_GFX_WAIT);
    assign lb_idx = {word_idx, ent_idx};
    assign lb_pal = entry.pal;
    assign lb_gfx = rdata;

endmodule

`default_nettype wire

// ==== rtl/vram_arbiter.sv ====
`default_nettype none

module vram_arbiter (
    input logic clk,
    input logic reset,

    input logic pal_req,
    input ppu_pkg::addr_t pal_addr,
    output logic pal_gnt,
    output logic pal_rvalid,

    input logic tile_req,
    input ppu_pkg::addr_t tile_addr,
    output logic tile_gnt,
    output logic tile_rvalid,

    output ppu_pkg::word_t rdata, // Shared return data

    output logic mem_rd,
    output ppu_pkg::addr_t mem_addr,
    input ppu_pkg::word_t mem_rdata
);

    import ppu_pkg::*;

    logic rd_q;        // A read was issued last cycle
    req_id_t last_id;  // Owner of that read

    // Palette loader wins any conflict
    always_comb begin
        pal_gnt = pal_req;
        tile_gnt = tile_req && !pal_req;
        mem_rd = pal_req || tile_req;
        mem_addr = pal_req ? pal_addr : tile_addr;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_q <= 1'b0;
            last_id <= REQ_PAL;
        end else begin
            rd_q <= mem_rd;
            if (mem_rd) begin
                last_id <= pal_gnt ? REQ_PAL : REQ_TILE;
            end
        end
    end

    // Memory answers one cycle after the strobe, steer it to the owner
    assign pal_rvalid = rd_q && (last_id == REQ_PAL);
    assign tile_rvalid = rd_q && (last_id == REQ_TILE);
    assign rdata = mem_rdata;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the PPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ppu \
    -f flist.f --Mdir obj_dir -o tb_ppu
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_ppu 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1
